// File: design/ads_pkg.sv
package ads_pkg;

	// ========================================
	// Frame geometry
	// ========================================
	localparam int NUM_CHANNELS = 2;      // ADS1292 has two channels
	localparam int SAMPLE_W     = 24;     // Bits per sample and per status word
	// Status word on top, then ch0, then ch1
	localparam int FRAME_W      = SAMPLE_W * (NUM_CHANNELS + 1);

	// Top nibble of every good status word
	localparam logic [3:0] STATUS_SYNC = 4'hC;

	// ========================================
	// Filter and output tagging
	// ========================================
	localparam int WINDOW_LOG2 = 2;       // 4-sample moving average
	localparam int CHAN_W      = 1;       // Enough bits for NUM_CHANNELS

	// Two's complement sample as delivered by the ADC
	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// Channel number sent along with each result
	typedef logic [CHAN_W-1:0] chan_t;

	// Output handshake FSM
	typedef enum logic [1:0] {
		COLL_IDLE,      // Waiting for a pending lane
		COLL_REQ,       // Request up, result on the bus
		COLL_RELEASE    // Waiting for the host to drop ack
	} coll_state_t;

endpackage

// File: design/ads_frame_splitter.sv
`timescale 1ns/1ps

module ads_frame_splitter (
	input  logic                             CLOCK_50M,
	input  logic                             rstn_btn,
	input  logic [ads_pkg::FRAME_W-1:0]      i_frame,          // Raw 72-bit SPI frame
	input  logic                             i_frame_valid,    // Single-cycle strobe
	input  logic [ads_pkg::NUM_CHANNELS-1:0] i_lane_pending,   // Lanes still holding a result
	output ads_pkg::sample_t                 o_lane_sample [ads_pkg::NUM_CHANNELS],
	output logic [ads_pkg::NUM_CHANNELS-1:0] o_lane_load,
	output logic [7:0]                       o_bad_frames,     // Saturating count
	output logic                             o_overrun         // Sticky until reset
);
	import ads_pkg::*;

	logic sync_ok;
	logic lanes_busy;
	logic accept;

	// ========================================
	// Frame qualification
	// ========================================
	assign sync_ok = (i_frame[FRAME_W-1 -: 4] == STATUS_SYNC);

	// A load already in flight counts as busy too
	// since pending only shows up one cycle after load
	assign lanes_busy = (|i_lane_pending) | (|o_lane_load);

	assign accept = i_frame_valid & sync_ok & ~lanes_busy;

	// Channel slices of the accepted frame
	always_ff @(posedge CLOCK_50M) begin
		if (accept) begin
			for (int k = 0; k < NUM_CHANNELS; k++) begin
				o_lane_sample[k] <= i_frame[FRAME_W-1-SAMPLE_W*(k+1) -: SAMPLE_W];
			end
		end
	end

	// ========================================
	// Strobes and status
	// ========================================
	always_ff @(posedge CLOCK_50M or negedge rstn_btn) begin
		if (!rstn_btn) begin
			o_lane_load  <= '0;
			o_bad_frames <= 8'd0;
			o_overrun    <= 1'b0;
		end else begin
			o_lane_load <= {NUM_CHANNELS{accept}};   // All lanes together

			// Lost sync, count it but never wrap
			if (i_frame_valid && !sync_ok && (o_bad_frames != 8'hFF))
				o_bad_frames <= o_bad_frames + 8'd1;

			// Good frame but no room for it
			if (i_frame_valid && sync_ok && lanes_busy)
				o_overrun <= 1'b1;
		end
	end

endmodule

// File: design/ads_channel_filter.sv
`timescale 1ns/1ps

module ads_channel_filter (
	input  logic             CLOCK_50M,
	input  logic             rstn_btn,
	input  ads_pkg::sample_t i_sample,   // New sample from the splitter
	input  logic             i_load,     // Shift i_sample into the window
	input  logic             i_take,     // Collector grabbed o_result
	output ads_pkg::sample_t o_result,   // Floored window average
	output logic             o_pending   // Result not yet taken
);
	import ads_pkg::*;

	localparam int DEPTH = 1 << WINDOW_LOG2;      // Window length
	localparam int SUM_W = SAMPLE_W + WINDOW_LOG2; // Sum never overflows

	sample_t                  hist [DEPTH];   // hist[0] is the newest
	logic signed [SUM_W-1:0]  run_sum;        // Sum of hist entries
	logic signed [SUM_W-1:0]  next_sum;

	// ========================================
	// Running window sum
	// ========================================
	// Oldest sample leaves, new one enters
	always_comb begin
		next_sum = run_sum;
		next_sum = next_sum + i_sample;
		next_sum = next_sum - hist[DEPTH-1];
	end

	always_ff @(posedge CLOCK_50M or negedge rstn_btn) begin
		if (!rstn_btn) begin
			for (int i = 0; i < DEPTH; i++) begin
				hist[i] <= '0;
			end
			run_sum <= '0;
		end else if (i_load) begin
			hist[0] <= i_sample;
			for (int i = 1; i < DEPTH; i++) begin
				hist[i] <= hist[i-1];    // Age the window
			end
			run_sum <= next_sum;
		end
	end

	// Dropping the low bits of a signed sum floors toward minus infinity
	always_ff @(posedge CLOCK_50M) begin
		if (i_load)
			o_result <= next_sum[SUM_W-1:WINDOW_LOG2];
	end

	// ========================================
	// Result handshake with the collector
	// ========================================
	always_ff @(posedge CLOCK_50M or negedge rstn_btn) begin
		if (!rstn_btn)
			o_pending <= 1'b0;
		else if (i_load)
			o_pending <= 1'b1;   // Fresh result
		else if (i_take)
			o_pending <= 1'b0;
	end

endmodule

// File: design/ads_result_collector.sv
`timescale 1ns/1ps

module ads_result_collector (
	input  logic                             CLOCK_50M,
	input  logic                             rstn_btn,
	input  ads_pkg::sample_t                 i_lane_result [ads_pkg::NUM_CHANNELS],
	input  logic [ads_pkg::NUM_CHANNELS-1:0] i_lane_pending,
	output logic [ads_pkg::NUM_CHANNELS-1:0] o_lane_take,   // One-cycle capture strobe
	output logic                             o_req,         // Four-phase request
	input  logic                             i_ack,         // Host acknowledge
	output ads_pkg::chan_t                   o_chan,        // Channel tag of o_data
	output ads_pkg::sample_t                 o_data
);
	import ads_pkg::*;

	coll_state_t state;
	logic        grant_valid;   // Some lane is pending
	chan_t       grant_idx;     // Lowest pending lane
	logic        capture;

	// ========================================
	// Fixed priority select
	// ========================================
	// Walk downward so the lowest index is assigned last and wins
	always_comb begin
		grant_valid = 1'b0;
		grant_idx   = '0;
		for (int k = NUM_CHANNELS - 1; k >= 0; k--) begin
			if (i_lane_pending[k]) begin
				grant_valid = 1'b1;
				grant_idx   = chan_t'(k);
			end
		end
	end

	// Never start a new request while ack is still up
	assign capture = (state == COLL_IDLE) && grant_valid && !i_ack;

	// Take goes out in the capture cycle itself
	always_comb begin
		o_lane_take = '0;
		if (capture)
			o_lane_take[grant_idx] = 1'b1;
	end

	// ========================================
	// Four-phase output FSM
	// ========================================
	always_ff @(posedge CLOCK_50M or negedge rstn_btn) begin
		if (!rstn_btn) begin
			state <= COLL_IDLE;
			o_req <= 1'b0;
		end else begin
			case (state)
				COLL_IDLE: begin
					if (capture) begin
						o_req <= 1'b1;          // Data is latched on the same edge
						state <= COLL_REQ;
					end
				end
				COLL_REQ: begin
					if (i_ack) begin
						o_req <= 1'b0;          // Host has the word
						state <= COLL_RELEASE;
					end
				end
				COLL_RELEASE: begin
					if (!i_ack)
						state <= COLL_IDLE;     // Handshake complete
				end
				default: begin
					o_req <= 1'b0;
					state <= COLL_IDLE;
				end
			endcase
		end
	end

	// Payload held steady for the whole request
	always_ff @(posedge CLOCK_50M) begin
		if (capture) begin
			o_chan <= grant_idx;
			o_data <= i_lane_result[grant_idx];
		end
	end

endmodule

// File: design/ads_filter_top.sv
`timescale 1ns/1ps

module ads_filter_top (
	input  logic                        CLOCK_50M,
	input  logic                        rstn_btn,
	// Frame from the SPI controller
	input  logic [ads_pkg::FRAME_W-1:0] i_frame,
	input  logic                        i_frame_valid,
	// Host side, four-phase
	output logic                        o_req,
	input  logic                        i_ack,
	output ads_pkg::chan_t              o_chan,
	output ads_pkg::sample_t            o_data,
	// Status
	output logic [7:0]                  o_bad_frames,
	output logic                        o_overrun
);
	import ads_pkg::*;

	sample_t                 lane_sample [NUM_CHANNELS];   // Splitter to filters
	sample_t                 lane_result [NUM_CHANNELS];   // Filters to collector
	logic [NUM_CHANNELS-1:0] lane_load;
	logic [NUM_CHANNELS-1:0] lane_pending;
	logic [NUM_CHANNELS-1:0] lane_take;

	// ========================================
	// Frame check and fan-out
	// ========================================
	ads_frame_splitter u_splitter (
		.CLOCK_50M      (CLOCK_50M),
		.rstn_btn       (rstn_btn),
		.i_frame        (i_frame),
		.i_frame_valid  (i_frame_valid),
		.i_lane_pending (lane_pending),
		.o_lane_sample  (lane_sample),
		.o_lane_load    (lane_load),
		.o_bad_frames   (o_bad_frames),
		.o_overrun      (o_overrun)
	);

	// One moving-average filter per channel
	for (genvar k = 0; k < NUM_CHANNELS; k++) begin : g_lane
		ads_channel_filter u_filter (
			.CLOCK_50M (CLOCK_50M),
			.rstn_btn  (rstn_btn),
			.i_sample  (lane_sample[k]),
			.i_load    (lane_load[k]),
			.i_take    (lane_take[k]),
			.o_result  (lane_result[k]),
			.o_pending (lane_pending[k])
		);
	end

	// Drains results to the host
	ads_result_collector u_collector (
		.CLOCK_50M      (CLOCK_50M),
		.rstn_btn       (rstn_btn),
		.i_lane_result  (lane_result),
		.i_lane_pending (lane_pending),
		.o_lane_take    (lane_take),
		.o_req          (o_req),
		.i_ack          (i_ack),
		.o_chan         (o_chan),
		.o_data         (o_data)
	);

endmodule

// File: verif/ads_filter_assert.sv
`timescale 1ns/1ps

module ads_filter_assert (
	input logic             CLOCK_50M,
	input logic             rstn_btn,
	input logic             i_req,       // Collector request
	input logic             i_ack,       // Host acknowledge
	input ads_pkg::chan_t   i_chan,
	input ads_pkg::sample_t i_data,
	input logic             i_overrun
);
	import ads_pkg::*;

	// ========================================
	// Four-phase output protocol
	// ========================================
	req_held: assert property (@(posedge CLOCK_50M) disable iff (!rstn_btn)
		(i_req && !i_ack) |=> i_req)   // No retraction before ack
		else $error("o_req fell before i_ack rose");

	payload_stable: assert property (@(posedge CLOCK_50M) disable iff (!rstn_btn)
		i_req |=> (!i_req || ($stable(i_chan) && $stable(i_data))))
		else $error("o_chan or o_data moved while o_req was high");

	// Ack still up from the last word blocks a new request
	no_req_on_ack: assert property (@(posedge CLOCK_50M) disable iff (!rstn_btn)
		(!i_req && i_ack) |=> !i_req)
		else $error("o_req rose while i_ack was still high");

	// Reset state
	reset_quiet: assert property (@(posedge CLOCK_50M)
		(!rstn_btn || $rose(rstn_btn)) |-> (!i_req && !i_overrun))
		else $error("o_req or o_overrun set during or right after reset");

endmodule

bind ads_filter_top ads_filter_assert u_assert (
	.CLOCK_50M (CLOCK_50M),
	.rstn_btn  (rstn_btn),
	.i_req     (o_req),
	.i_ack     (i_ack),
	.i_chan    (o_chan),
	.i_data    (o_data),
	.i_overrun (o_overrun)
);

// File: verif/ads_filter_tb.sv
`timescale 1ns/1ps

module ads_filter_tb;
	import ads_pkg::*;

	localparam int          CLK_PERIOD   = 20;
	localparam int          RESET_CYCLES = 4;
	localparam logic [15:0] LFSR_SEED    = 16'd46174;
	localparam logic [19:0] STATUS_LOW   = 20'h5A3C1;   // Lead-off bits left undecoded
	localparam int          REF_DEPTH    = 4;           // Averaging window
	localparam int          N_RANDOM     = 20;          // Test 2 frames
	localparam int          N_MIXED      = 12;          // Test 3 random good/bad frames
	localparam int          HOLD_CYCLES  = 8;           // Ack withheld in test 4
	localparam int          N_FRAMES     = N_RANDOM + N_MIXED + 2 + 3 + 9;
	localparam int          WATCHDOG_NS  = (N_FRAMES * 64 + 100 + HOLD_CYCLES) * CLK_PERIOD;
	localparam sample_t     FS_NEG       = 24'sh800000;
	localparam sample_t     FS_POS       = 24'sh7FFFFF;

	logic               CLOCK_50M;
	logic               rstn_btn;
	logic [FRAME_W-1:0] i_frame;
	logic               i_frame_valid;
	logic               i_ack;
	logic               o_req;
	chan_t              o_chan;
	sample_t            o_data;
	logic [7:0]         o_bad_frames;
	logic               o_overrun;

	logic [15:0] stim_lfsr;                    // Stimulus data stream
	logic [15:0] host_lfsr;                    // Ack delay stream
	logic        hold_ack;                     // Host stalls when set
	sample_t     win [NUM_CHANNELS][REF_DEPTH];   // Reference history, [0] newest
	chan_t       exp_chan_q [$];
	sample_t     exp_data_q [$];
	logic [7:0]  exp_bad;
	logic        exp_overrun;
	int          results_pushed;
	int          results_seen;

	ads_filter_top dut0 (.*);

	initial begin : clock_gen
		CLOCK_50M = 1'b0;
		forever #(CLK_PERIOD / 2) CLOCK_50M = ~CLOCK_50M;
	end

	// ========================================
	// Random source and reference model
	// ========================================
	// Taps 16 14 13 11 with the new bit entering at the bottom
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	task automatic take_bits(input int n, output logic [23:0] bits);
		bits = '0;
		repeat (n) begin
			stim_lfsr = lfsr_next(stim_lfsr);
			bits = {bits[22:0], stim_lfsr[0]};
		end
	endtask

	// Push sample into the channel window and return the mean floored toward minus infinity
	function automatic sample_t ref_average(input int ch, input sample_t s);
		longint sum;
		longint mean;
		for (int i = REF_DEPTH - 1; i > 0; i--)
			win[ch][i] = win[ch][i-1];
		win[ch][0] = s;
		sum = 0;
		for (int i = 0; i < REF_DEPTH; i++)
			sum += win[ch][i];
		mean = sum / REF_DEPTH;                  // Truncates toward zero
		if ((sum % REF_DEPTH != 0) && (sum < 0))
			mean = mean - 1;
		return sample_t'(mean);
	endfunction

	// ========================================
	// Checks
	// ========================================
	task automatic abort_run();
		$display("SOME TESTS FAILED");
		$fatal(1, "Run stopped at first error");
	endtask

	task automatic check_chan(input string name, input chan_t want, input chan_t got);
		if (got !== want) begin
			$display("MISMATCH at %0t: %s expected %0d got %0d", $time, name, want, got);
			abort_run();
		end
	endtask

	task automatic check_sample(input string name, input sample_t want, input sample_t got);
		if (got !== want) begin
			$display("MISMATCH at %0t: %s expected %0d got %0d", $time, name, want, got);
			abort_run();
		end
	endtask

	task automatic check_count(input string name, input logic [7:0] want, input logic [7:0] got);
		if (got !== want) begin
			$display("MISMATCH at %0t: %s expected %0d got %0d", $time, name, want, got);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic want, input logic got);
		if (got !== want) begin
			$display("MISMATCH at %0t: %s expected %b got %b", $time, name, want, got);
			abort_run();
		end
	endtask

	// ========================================
	// Frame drivers
	// ========================================
	// busy tells whether lanes still hold untaken results
	task automatic send_frame(input sample_t s0, input sample_t s1,
			input logic [3:0] nib, input logic busy);
		@(negedge CLOCK_50M);
		i_frame       = {nib, STATUS_LOW, s0, s1};
		i_frame_valid = 1'b1;
		if (nib != STATUS_SYNC) begin
			if (exp_bad != 8'hFF)
				exp_bad = exp_bad + 8'd1;   // Saturates at 255
		end else if (busy) begin
			exp_overrun = 1'b1;             // Frame dropped and flag stays set
		end else begin
			exp_chan_q.push_back(chan_t'(0));
			exp_data_q.push_back(ref_average(0, s0));
			exp_chan_q.push_back(chan_t'(1));
			exp_data_q.push_back(ref_average(1, s1));
			results_pushed += NUM_CHANNELS;
		end
		@(negedge CLOCK_50M);
		i_frame_valid = 1'b0;
	endtask

	task automatic send_random_frame(input logic [3:0] nib, input logic busy);
		logic [23:0] a;
		logic [23:0] b;
		take_bits(24, a);
		take_bits(24, b);
		send_frame(sample_t'(a), sample_t'(b), nib, busy);
	endtask

	// All results delivered and handshake back to rest
	task automatic wait_drained();
		@(negedge CLOCK_50M);
		while ((exp_chan_q.size() != 0) || o_req || i_ack)
			@(negedge CLOCK_50M);
	endtask

	task automatic send_good_frame(input sample_t s0, input sample_t s1);
		send_frame(s0, s1, STATUS_SYNC, 1'b0);
		wait_drained();
	endtask

	// ========================================
	// Host and result compare
	// ========================================
	// Two LFSR bits give a host delay of 0 to 3 cycles
	task automatic draw_ack_delay(output int cycles);
		cycles = 0;
		repeat (2) begin
			host_lfsr = lfsr_next(host_lfsr);
			cycles    = cycles * 2 + host_lfsr[0];
		end
	endtask

	initial begin : host_ack
		int wait_cycles;
		i_ack     = 1'b0;
		host_lfsr = LFSR_SEED;
		forever begin
			@(negedge CLOCK_50M);
			if (o_req && !i_ack && !hold_ack) begin
				draw_ack_delay(wait_cycles);
				repeat (wait_cycles) @(negedge CLOCK_50M);
				i_ack = 1'b1;
				while (o_req) @(negedge CLOCK_50M);
				draw_ack_delay(wait_cycles);   // Ack may linger past req
				repeat (wait_cycles) @(negedge CLOCK_50M);
				i_ack = 1'b0;                // Release after req falls
			end
		end
	end

	initial begin : compare_results
		logic    req_d;
		chan_t   want_chan;
		sample_t want_data;
		req_d        = 1'b0;
		results_seen = 0;
		forever begin
			@(negedge CLOCK_50M);
			if (o_req && !req_d) begin       // New word on the bus
				if (exp_chan_q.size() == 0) begin
					$display("ERROR at %0t: result for channel %0d with none expected",
						$time, o_chan);
					abort_run();
				end else begin
					want_chan = exp_chan_q.pop_front();
					want_data = exp_data_q.pop_front();
					check_chan("o_chan", want_chan, o_chan);
					check_sample("o_data", want_data, o_data);
					results_seen++;
				end
			end
			req_d = o_req;
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("ERROR at %0t: output handshake stalled, watchdog expired", $time);
		abort_run();
	end

	// ========================================
	// Test sequence
	// ========================================
	initial begin : main_seq
		logic [23:0] pick;
		logic [3:0]  nib;
		sample_t     held;
		rstn_btn       = 1'b0;
		i_frame        = '0;
		i_frame_valid  = 1'b0;
		hold_ack       = 1'b0;
		stim_lfsr      = LFSR_SEED;
		exp_bad        = 8'd0;
		exp_overrun    = 1'b0;
		results_pushed = 0;
		for (int ch = 0; ch < NUM_CHANNELS; ch++)
			for (int i = 0; i < REF_DEPTH; i++)
				win[ch][i] = '0;
		repeat (RESET_CYCLES) @(posedge CLOCK_50M);
		@(negedge CLOCK_50M);
		rstn_btn = 1'b1;

		// Test 1 checks the reset state
		@(negedge CLOCK_50M);
		check_flag("o_req", 1'b0, o_req);
		check_count("o_bad_frames", 8'd0, o_bad_frames);
		check_flag("o_overrun", 1'b0, o_overrun);

		// Test 2 drains random good frames one by one
		for (int f = 0; f < N_RANDOM; f++) begin
			send_random_frame(STATUS_SYNC, 1'b0);
			wait_drained();
		end

		// Test 3 mixes in frames whose sync nibble has bit 0 flipped
		send_random_frame(STATUS_SYNC ^ 4'h3, 1'b0);
		for (int f = 0; f < N_MIXED; f++) begin
			take_bits(4, pick);
			nib = pick[0] ? (STATUS_SYNC ^ {pick[3:1], 1'b1}) : STATUS_SYNC;
			send_random_frame(nib, 1'b0);
			wait_drained();
		end
		send_random_frame(STATUS_SYNC, 1'b0);
		wait_drained();
		check_count("o_bad_frames", exp_bad, o_bad_frames);
		check_flag("o_overrun", 1'b0, o_overrun);

		// Test 4 stalls the host so the second frame is dropped
		hold_ack = 1'b1;
		send_random_frame(STATUS_SYNC, 1'b0);
		held = exp_data_q[0];
		while (!o_req) @(negedge CLOCK_50M);
		send_random_frame(STATUS_SYNC, 1'b1);   // Lane 1 still pending
		repeat (HOLD_CYCLES) @(negedge CLOCK_50M);
		check_flag("o_req", 1'b1, o_req);
		check_chan("o_chan", chan_t'(0), o_chan);
		check_sample("o_data", held, o_data);
		check_flag("o_overrun", exp_overrun, o_overrun);
		hold_ack = 1'b0;
		wait_drained();
		send_random_frame(STATUS_SYNC, 1'b0);   // Window must skip the dropped one
		wait_drained();
		check_flag("o_overrun", 1'b1, o_overrun);

		// Test 5 covers full scale and odd sums
		repeat (REF_DEPTH) send_good_frame(FS_NEG, FS_POS);
		send_good_frame(-24'sd1, 24'sd1);
		send_good_frame(-24'sd3, 24'sd3);
		send_good_frame(24'sd5, -24'sd5);
		send_good_frame(-24'sd7, 24'sd7);
		send_good_frame(24'sd1, -24'sd1);
		check_count("o_bad_frames", exp_bad, o_bad_frames);

		if ((exp_chan_q.size() == 0) && (results_seen == results_pushed)) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			$display("ERROR: %0d results expected, %0d seen", results_pushed, results_seen);
			abort_run();
		end
	end

endmodule

// File: verilog.f
design/ads_pkg.sv
design/ads_frame_splitter.sv
design/ads_channel_filter.sv
design/ads_result_collector.sv
design/ads_filter_top.sv
verif/ads_filter_assert.sv
verif/ads_filter_tb.sv
